//--- vchess_settings.svh
`ifndef VCHESS_SETTINGS_SVH
`define VCHESS_SETTINGS_SVH

`define SIDE_WIDTH          32
`define BOARD_WORDS         8
`define BOARD_WIDTH         256 // SIDE_WIDTH * BOARD_WORDS
`define EVAL_WIDTH          24
`define HALF_MOVE_WIDTH     10
`define MAX_POSITIONS_LOG2  7
`define UCI_WIDTH           16

`define AXIL_ADDR_WIDTH     16
`define AXIL_DATA_WIDTH     32
`define REG_ADDR_WIDTH      14 // Word index from address bits 15:2

// Host-written configuration words
`define REG_CONTROL         0
`define REG_MOVE_INDEX      1
`define REG_POS_STATE       2
`define REG_HALF_MOVE       3
`define REG_CAPTURE_MOVES   4
`define REG_NEW_BOARD       8 // Eight side words up to 15

// Generator result words
`define REG_RESULT_FLAGS     132
`define REG_RESULT_POS       133
`define REG_RESULT_EVAL      134
`define REG_MOVE_COUNT       135
`define REG_INITIAL_EVAL     136
`define REG_RESULT_HALF_MOVE 138
`define REG_RESULT_UCI       139
`define REG_RESULT_BOARD     172 // Eight side words up to 179

`define CTRL_NEW_BOARD_BIT   0
`define CTRL_CLEAR_MOVES_BIT 1
`define CTRL_RANDOM_BIT      30
`define CTRL_SOFT_RESET_BIT  31

`define AXI_RESP_OKAY        2'b00

`endif

//--- vchess_pkg.sv
`include "vchess_settings.svh"

package vchess_pkg;

   typedef logic [`BOARD_WORDS-1:0][`SIDE_WIDTH-1:0] board_t;

   typedef struct packed {
      logic       white_to_move;
      logic [3:0] castle_mask;
      logic [3:0] en_passant_col;
   } pos_state_t;

   typedef struct packed {
      logic                           new_board_valid;
      logic                           clear_moves;
      logic                           use_random_bit;
      logic                           soft_reset;
      logic [`MAX_POSITIONS_LOG2-1:0] move_index;
      pos_state_t                     pos;
      logic [`HALF_MOVE_WIDTH-1:0]    half_move;
      logic                           capture_moves; // Generate captures only
      board_t                         new_board;
   } ctrl_cfg_t;

   typedef struct packed {
      logic                           idle;
      logic                           moves_ready; // All moves calculated
      logic                           move_ready;  // Indexed move valid
      logic                           mate;
      logic                           stalemate;
      logic                           thrice_rep;
      logic                           fifty_move;
      logic                           insufficient_material;
      logic                           board_check;
      logic [`EVAL_WIDTH-1:0]         initial_eval; // Root node eval, signed
      logic [`MAX_POSITIONS_LOG2-1:0] move_count;
   } gen_status_t;

   typedef struct packed {
      board_t                      board;
      pos_state_t                  pos;
      logic                        capture;
      logic                        white_in_check;
      logic                        black_in_check;
      logic                        thrice_rep;
      logic                        fifty_move;
      logic                        insufficient_material;
      logic [`EVAL_WIDTH-1:0]      eval; // Signed
      logic [`HALF_MOVE_WIDTH-1:0] half_move;
      logic [`UCI_WIDTH-1:0]       uci;
   } move_record_t;

   typedef struct packed {
      logic [`AXIL_ADDR_WIDTH-1:0] awaddr;
   } axil_aw_t;

   typedef struct packed {
      logic [`AXIL_DATA_WIDTH-1:0] wdata;
   } axil_w_t;

   typedef struct packed {
      logic                        valid;
      logic [`REG_ADDR_WIDTH-1:0]  addr;
      logic [`AXIL_DATA_WIDTH-1:0] data;
   } reg_wr_t;

endpackage

//--- axil_hold_reg.sv
`timescale 1ns/1ns

module axil_hold_reg
#(
   parameter type payload_t = logic
)
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,
   input  logic     take,
   output logic     full,
   output payload_t data
);

   assign in_ready = !full;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         full <= 1'b0;
      else if (in_valid && in_ready)
         full <= 1'b1;
      else if (take)
         full <= 1'b0; // Only taken while full
   end

   always_ff @(posedge clk)
   begin
      if (in_valid && in_ready)
         data <= in_data;
   end

endmodule

//--- axil_write_channel.sv
`timescale 1ns/1ns

`include "vchess_settings.svh"

module axil_write_channel
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic [`AXIL_ADDR_WIDTH-1:0] awaddr,
   input  logic                        awvalid,
   output logic                        awready,
   input  logic [`AXIL_DATA_WIDTH-1:0] wdata,
   input  logic                        wvalid,
   output logic                        wready,
   output logic                        bvalid,
   input  logic                        bready,
   output logic [1:0]                  bresp,
   output vchess_pkg::reg_wr_t         reg_wr
);
   import vchess_pkg::*;

   axil_aw_t aw_in;
   axil_aw_t aw_held;
   axil_w_t  w_in;
   axil_w_t  w_held;
   logic     aw_full;
   logic     w_full;
   logic     b_stall;
   logic     fire;

   assign aw_in.awaddr = awaddr;
   assign w_in.wdata   = wdata;

   // Response still waiting on the host
   assign b_stall = bvalid && !bready;
   assign fire    = aw_full && w_full && !b_stall;

   axil_hold_reg #(.payload_t(axil_aw_t)) i_aw_hold
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_valid (awvalid),
      .in_ready (awready),
      .in_data  (aw_in),
      .take     (fire),
      .full     (aw_full),
      .data     (aw_held)
   );

   axil_hold_reg #(.payload_t(axil_w_t)) i_w_hold
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_valid (wvalid),
      .in_ready (wready),
      .in_data  (w_in),
      .take     (fire),
      .full     (w_full),
      .data     (w_held)
   );

   assign reg_wr.valid = fire;
   assign reg_wr.addr  = aw_held.awaddr[`AXIL_ADDR_WIDTH-1:2]; // Drop byte offset
   assign reg_wr.data  = w_held.wdata;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         bvalid <= 1'b0;
      else if (fire)
         bvalid <= 1'b1;
      else if (bready)
         bvalid <= 1'b0;
   end

   assign bresp = `AXI_RESP_OKAY;

endmodule

//--- axil_read_channel.sv
`timescale 1ns/1ns

`include "vchess_settings.svh"

module axil_read_channel
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic [`AXIL_ADDR_WIDTH-1:0] araddr,
   input  logic                        arvalid,
   output logic                        arready,
   output logic                        rvalid,
   input  logic                        rready,
   output logic [`AXIL_DATA_WIDTH-1:0] rdata,
   output logic [1:0]                  rresp,
   output logic [`REG_ADDR_WIDTH-1:0]  rd_addr,
   input  logic [`AXIL_DATA_WIDTH-1:0] rd_data
);

   logic ar_fire;

   assign arready = !rvalid; // One read in flight
   assign ar_fire = arvalid && arready;
   assign rd_addr = araddr[`AXIL_ADDR_WIDTH-1:2];

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         rvalid <= 1'b0;
      else if (ar_fire)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;
   end

   // Status is sampled on the AR edge and held until rready
   always_ff @(posedge clk)
   begin
      if (ar_fire)
         rdata <= rd_data;
   end

   assign rresp = `AXI_RESP_OKAY;

endmodule

//--- ctrl_regs.sv
`timescale 1ns/1ns

`include "vchess_settings.svh"

module ctrl_regs
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  vchess_pkg::reg_wr_t   reg_wr,
   output vchess_pkg::ctrl_cfg_t cfg
);
   import vchess_pkg::*;

   localparam int BOARD_SEL_WIDTH = $clog2(`BOARD_WORDS);
   localparam logic [`REG_ADDR_WIDTH-1:0] BOARD_BASE = `REG_NEW_BOARD;

   logic [`REG_ADDR_WIDTH-1:0] board_off;
   logic [BOARD_SEL_WIDTH-1:0] board_sel;

   assign board_off = reg_wr.addr - BOARD_BASE;
   assign board_sel = board_off[BOARD_SEL_WIDTH-1:0]; // Side word within the board

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         cfg <= '0;
      end
      else if (reg_wr.valid)
      begin
         case (reg_wr.addr) inside
            `REG_CONTROL:
            begin
               cfg.new_board_valid <= reg_wr.data[`CTRL_NEW_BOARD_BIT];
               cfg.clear_moves     <= reg_wr.data[`CTRL_CLEAR_MOVES_BIT];
               cfg.use_random_bit  <= reg_wr.data[`CTRL_RANDOM_BIT];
               cfg.soft_reset      <= reg_wr.data[`CTRL_SOFT_RESET_BIT];
            end
            `REG_MOVE_INDEX:
               cfg.move_index <= reg_wr.data[`MAX_POSITIONS_LOG2-1:0];
            `REG_POS_STATE:
               cfg.pos <= reg_wr.data[$bits(pos_state_t)-1:0]; // {wtm, castle, ep col}
            `REG_HALF_MOVE:
               cfg.half_move <= reg_wr.data[`HALF_MOVE_WIDTH-1:0];
            `REG_CAPTURE_MOVES:
               cfg.capture_moves <= reg_wr.data[0];
            [`REG_NEW_BOARD:`REG_NEW_BOARD + `BOARD_WORDS - 1]:
               cfg.new_board[board_sel] <= reg_wr.data[`SIDE_WIDTH-1:0];
            default:
            begin
               // Unmapped words are dropped
            end
         endcase
      end
   end

endmodule

//--- status_read_mux.sv
`timescale 1ns/1ns

`include "vchess_settings.svh"

module status_read_mux
(
   input  logic [`REG_ADDR_WIDTH-1:0]  rd_addr,
   input  vchess_pkg::ctrl_cfg_t       cfg,
   input  vchess_pkg::gen_status_t     gen_status,
   input  vchess_pkg::move_record_t    move_rec,
   output logic [`AXIL_DATA_WIDTH-1:0] rd_data
);
   import vchess_pkg::*;

   localparam int BOARD_SEL_WIDTH = $clog2(`BOARD_WORDS);
   localparam logic [`REG_ADDR_WIDTH-1:0] CFG_BOARD_BASE = `REG_NEW_BOARD;
   localparam logic [`REG_ADDR_WIDTH-1:0] RES_BOARD_BASE = `REG_RESULT_BOARD;

   logic [`REG_ADDR_WIDTH-1:0] cfg_off;
   logic [`REG_ADDR_WIDTH-1:0] res_off;

   function automatic logic [`AXIL_DATA_WIDTH-1:0] sext_eval(input logic [`EVAL_WIDTH-1:0] v);
      return {{(`AXIL_DATA_WIDTH - `EVAL_WIDTH){v[`EVAL_WIDTH-1]}}, v};
   endfunction

   assign cfg_off = rd_addr - CFG_BOARD_BASE;
   assign res_off = rd_addr - RES_BOARD_BASE;

   always_comb
   begin
      rd_data = '0;
      case (rd_addr) inside
         `REG_CONTROL:
         begin
            rd_data[`CTRL_NEW_BOARD_BIT]   = cfg.new_board_valid;
            rd_data[`CTRL_CLEAR_MOVES_BIT] = cfg.clear_moves;
            rd_data[2]                     = gen_status.moves_ready;
            rd_data[3]                     = gen_status.move_ready;
            rd_data[4]                     = gen_status.stalemate;
            rd_data[5]                     = gen_status.mate;
            rd_data[6]                     = gen_status.thrice_rep;
            rd_data[7]                     = gen_status.idle;
            rd_data[8]                     = gen_status.fifty_move;
            rd_data[9]                     = gen_status.insufficient_material;
            rd_data[10]                    = gen_status.board_check;
            rd_data[`CTRL_RANDOM_BIT]      = cfg.use_random_bit;
            rd_data[`CTRL_SOFT_RESET_BIT]  = cfg.soft_reset;
         end
         `REG_MOVE_INDEX:    rd_data = `AXIL_DATA_WIDTH'(cfg.move_index);
         `REG_POS_STATE:     rd_data = `AXIL_DATA_WIDTH'(cfg.pos);
         `REG_HALF_MOVE:     rd_data = `AXIL_DATA_WIDTH'(cfg.half_move);
         `REG_CAPTURE_MOVES: rd_data = `AXIL_DATA_WIDTH'(cfg.capture_moves);
         [`REG_NEW_BOARD:`REG_NEW_BOARD + `BOARD_WORDS - 1]:
            rd_data = `AXIL_DATA_WIDTH'(cfg.new_board[cfg_off[BOARD_SEL_WIDTH-1:0]]);
         `REG_RESULT_FLAGS:
            rd_data = `AXIL_DATA_WIDTH'({move_rec.insufficient_material, move_rec.fifty_move,
                                         move_rec.thrice_rep, move_rec.black_in_check,
                                         move_rec.white_in_check, move_rec.capture});
         `REG_RESULT_POS:       rd_data = `AXIL_DATA_WIDTH'(move_rec.pos);
         `REG_RESULT_EVAL:      rd_data = sext_eval(move_rec.eval);
         `REG_MOVE_COUNT:       rd_data = `AXIL_DATA_WIDTH'(gen_status.move_count);
         `REG_INITIAL_EVAL:     rd_data = sext_eval(gen_status.initial_eval);
         `REG_RESULT_HALF_MOVE: rd_data = `AXIL_DATA_WIDTH'(move_rec.half_move);
         `REG_RESULT_UCI:
            // Square fields on nibble boundaries for the host
            rd_data = `AXIL_DATA_WIDTH'({move_rec.uci[15:12], 1'b0, move_rec.uci[11:9],
                                         1'b0, move_rec.uci[8:6], 1'b0, move_rec.uci[5:3],
                                         1'b0, move_rec.uci[2:0]});
         [`REG_RESULT_BOARD:`REG_RESULT_BOARD + `BOARD_WORDS - 1]:
            rd_data = `AXIL_DATA_WIDTH'(move_rec.board[res_off[BOARD_SEL_WIDTH-1:0]]);
         default:
            rd_data = '0;
      endcase
   end

endmodule

//--- vchess_ctrl.sv
`timescale 1ns/1ns

`include "vchess_settings.svh"

module vchess_ctrl
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic [`AXIL_ADDR_WIDTH-1:0] awaddr,
   input  logic                        awvalid,
   output logic                        awready,
   input  logic [`AXIL_DATA_WIDTH-1:0] wdata,
   input  logic                        wvalid,
   output logic                        wready,
   output logic                        bvalid,
   input  logic                        bready,
   output logic [1:0]                  bresp,
   input  logic [`AXIL_ADDR_WIDTH-1:0] araddr,
   input  logic                        arvalid,
   output logic                        arready,
   output logic                        rvalid,
   input  logic                        rready,
   output logic [`AXIL_DATA_WIDTH-1:0] rdata,
   output logic [1:0]                  rresp,
   input  vchess_pkg::gen_status_t     gen_status,
   input  vchess_pkg::move_record_t    move_rec,
   output vchess_pkg::ctrl_cfg_t       cfg
);
   import vchess_pkg::*;

   reg_wr_t                     reg_wr;
   logic [`REG_ADDR_WIDTH-1:0]  rd_addr;
   logic [`AXIL_DATA_WIDTH-1:0] rd_data;

   axil_write_channel i_write_channel
   (
      .clk     (clk),
      .rst_n   (rst_n),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wvalid  (wvalid),
      .wready  (wready),
      .bvalid  (bvalid),
      .bready  (bready),
      .bresp   (bresp),
      .reg_wr  (reg_wr)
   );

   axil_read_channel i_read_channel
   (
      .clk     (clk),
      .rst_n   (rst_n),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rvalid  (rvalid),
      .rready  (rready),
      .rdata   (rdata),
      .rresp   (rresp),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   ctrl_regs i_ctrl_regs
   (
      .clk    (clk),
      .rst_n  (rst_n),
      .reg_wr (reg_wr),
      .cfg    (cfg)
   );

   status_read_mux i_read_mux
   (
      .rd_addr    (rd_addr),
      .cfg        (cfg),
      .gen_status (gen_status),
      .move_rec   (move_rec),
      .rd_data    (rd_data)
   );

endmodule

//--- tb_axil_tasks.svh
// AW and W start in the given order with the later one gap + 1 cycles behind
task automatic axil_write(input logic [`AXIL_ADDR_WIDTH-1:0] addr,
                          input logic [`AXIL_DATA_WIDTH-1:0] data,
                          input int order, input logic [1:0] gap);
   int          aw_delay;
   int          w_delay;
   int          cyc;
   bit          aw_done;
   bit          w_done;
   bit          aw_go;
   bit          w_go;
   bit          b_go;
   logic [31:0] r;
   aw_delay = (order == 1) ? gap + 1 : 0; // W first
   w_delay  = (order == 0) ? gap + 1 : 0; // AW first
   aw_done  = 1'b0;
   w_done   = 1'b0;
   b_go     = 1'b0;
   cyc      = 0;
   while (!(aw_done && w_done))
   begin
      if (!aw_done && cyc >= aw_delay)
      begin
         awaddr  = addr;
         awvalid = 1'b1;
      end
      if (!w_done && cyc >= w_delay)
      begin
         wdata  = data;
         wvalid = 1'b1;
      end
      aw_go = awvalid && awready;
      w_go  = wvalid && wready;
      @(posedge clk);
      #1;
      if (aw_go)
      begin
         aw_done = 1'b1;
         awvalid = 1'b0;
      end
      if (w_go)
      begin
         w_done = 1'b1;
         wvalid = 1'b0;
      end
      cyc++;
   end
   while (!b_go)
   begin
      get_rand(1, r);
      bready = r[0]; // Random back-pressure
      b_go   = bvalid && bready;
      if (b_go)
         check_value("bresp", bresp, `AXI_RESP_OKAY);
      @(posedge clk);
      #1;
   end
   bready = 1'b0;
   if (bvalid)
      protocol_error("bvalid still high after the B handshake");
endtask

task automatic axil_read(input logic [`AXIL_ADDR_WIDTH-1:0] addr,
                         output logic [`AXIL_DATA_WIDTH-1:0] data);
   bit          ar_go;
   bit          r_go;
   bit          held;
   logic [31:0] first;
   logic [31:0] r;
   ar_go   = 1'b0;
   r_go    = 1'b0;
   held    = 1'b0;
   first   = '0;
   araddr  = addr;
   arvalid = 1'b1;
   while (!ar_go)
   begin
      ar_go = arready;
      @(posedge clk);
      #1;
   end
   arvalid = 1'b0;
   while (!r_go)
   begin
      get_rand(1, r);
      rready = r[0];
      if (rvalid)
      begin
         if (!held)
         begin
            first = rdata;
            held  = 1'b1;
         end
         else if (rdata !== first)
            protocol_error("rdata changed while rvalid waited for rready");
         if (arready)
            protocol_error("arready high while a read response is pending");
         check_value("rresp", rresp, `AXI_RESP_OKAY);
      end
      r_go = rvalid && rready;
      @(posedge clk);
      #1;
   end
   rready = 1'b0;
   data   = first;
endtask

//--- tb_vchess_ctrl.sv
`timescale 1ns/1ns

`include "vchess_settings.svh"

module tb_vchess_ctrl;
   import vchess_pkg::*;

   localparam int RESET_CYCLES   = 8;
   localparam int CFG_ADDRS      = 13;
   localparam int RANDOM_WRITES  = 200;
   localparam int UNMAPPED_ADDRS = 8;
   localparam int STATUS_ROUNDS  = 4;
   localparam int STATUS_ADDRS   = 17;
   localparam int ORDER_ROUNDS   = 4;
   // Writes in phases 2, 3 and 5 are each followed by a read
   localparam int NUM_TRANS = CFG_ADDRS + 2 * RANDOM_WRITES + 2 * UNMAPPED_ADDRS
                              + STATUS_ROUNDS * STATUS_ADDRS + 2 * 3 * ORDER_ROUNDS;
   localparam int TIMEOUT_CYCLES = 40 * NUM_TRANS + RESET_CYCLES;

   logic                        clk;
   logic                        rst_n;
   logic [`AXIL_ADDR_WIDTH-1:0] awaddr;
   logic                        awvalid;
   logic                        awready;
   logic [`AXIL_DATA_WIDTH-1:0] wdata;
   logic                        wvalid;
   logic                        wready;
   logic                        bvalid;
   logic                        bready;
   logic [1:0]                  bresp;
   logic [`AXIL_ADDR_WIDTH-1:0] araddr;
   logic                        arvalid;
   logic                        arready;
   logic                        rvalid;
   logic                        rready;
   logic [`AXIL_DATA_WIDTH-1:0] rdata;
   logic [1:0]                  rresp;
   gen_status_t                 gen_status;
   move_record_t                move_rec;
   ctrl_cfg_t                   cfg;
   ctrl_cfg_t                   model_cfg;
   logic [15:0]                 lfsr_state;
   int                          value_errors = 0;
   int                          protocol_errors = 0;
   int                          cycle_count = 0;
   int                          strobe_count = 0;

   vchess_ctrl i_dut (.*);

   initial clk = 1'b0;
   always #5 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   // Count one register update strobe per completed write
   always @(negedge clk)
      if (rst_n && i_dut.reg_wr.valid)
         strobe_count++;

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic get_rand(input int n, output logic [31:0] v);
      int i;
      v = '0;
      for (i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
   endtask

   task automatic check_value(input string name, input logic [319:0] got,
                              input logic [319:0] exp);
      if (got !== exp)
      begin
         $display("Fail %s: got %0h, expected %0h at %0t", name, got, exp, $time);
         value_errors++;
      end
   endtask

   task automatic protocol_error(input string what);
      $display("Protocol error at %0t: %s", $time, what);
      protocol_errors++;
   endtask

   function automatic logic [`REG_ADDR_WIDTH-1:0] cfg_addr(input int i);
      if (i < 5)
         return i; // Words 0 to 4
      return `REG_NEW_BOARD + i - 5;
   endfunction

   task automatic model_write(input logic [`REG_ADDR_WIDTH-1:0] idx, input logic [31:0] d);
      if (idx == `REG_CONTROL)
      begin
         model_cfg.new_board_valid = d[`CTRL_NEW_BOARD_BIT];
         model_cfg.clear_moves     = d[`CTRL_CLEAR_MOVES_BIT];
         model_cfg.use_random_bit  = d[`CTRL_RANDOM_BIT];
         model_cfg.soft_reset      = d[`CTRL_SOFT_RESET_BIT];
      end
      else if (idx == `REG_MOVE_INDEX)
         model_cfg.move_index = d[`MAX_POSITIONS_LOG2-1:0];
      else if (idx == `REG_POS_STATE)
      begin
         model_cfg.pos.white_to_move  = d[8];
         model_cfg.pos.castle_mask    = d[7:4];
         model_cfg.pos.en_passant_col = d[3:0];
      end
      else if (idx == `REG_HALF_MOVE)
         model_cfg.half_move = d[`HALF_MOVE_WIDTH-1:0];
      else if (idx == `REG_CAPTURE_MOVES)
         model_cfg.capture_moves = d[0];
      else if (idx >= `REG_NEW_BOARD && idx < `REG_NEW_BOARD + `BOARD_WORDS)
         model_cfg.new_board[idx - `REG_NEW_BOARD] = d;
   endtask

   function automatic logic [31:0] expected_read(input logic [`REG_ADDR_WIDTH-1:0] idx);
      logic [31:0] v;
      int          k;
      v = '0;
      case (idx)
         `REG_CONTROL:
         begin
            v[`CTRL_NEW_BOARD_BIT]   = model_cfg.new_board_valid;
            v[`CTRL_CLEAR_MOVES_BIT] = model_cfg.clear_moves;
            v[`CTRL_RANDOM_BIT]      = model_cfg.use_random_bit;
            v[`CTRL_SOFT_RESET_BIT]  = model_cfg.soft_reset;
            v[10:2] = {gen_status.board_check, gen_status.insufficient_material,
                       gen_status.fifty_move, gen_status.idle, gen_status.thrice_rep,
                       gen_status.mate, gen_status.stalemate, gen_status.move_ready,
                       gen_status.moves_ready};
         end
         `REG_MOVE_INDEX:       v[6:0] = model_cfg.move_index;
         `REG_POS_STATE:        v[8:0] = model_cfg.pos;
         `REG_HALF_MOVE:        v[9:0] = model_cfg.half_move;
         `REG_CAPTURE_MOVES:    v[0] = model_cfg.capture_moves;
         `REG_RESULT_FLAGS:
         begin
            v[0] = move_rec.capture;
            v[1] = move_rec.white_in_check;
            v[2] = move_rec.black_in_check;
            v[3] = move_rec.thrice_rep;
            v[4] = move_rec.fifty_move;
            v[5] = move_rec.insufficient_material;
         end
         `REG_RESULT_POS:       v[8:0] = move_rec.pos;
         `REG_MOVE_COUNT:       v[6:0] = gen_status.move_count;
         `REG_RESULT_HALF_MOVE: v[9:0] = move_rec.half_move;
         `REG_RESULT_EVAL:
         begin
            v[23:0] = move_rec.eval;
            if (move_rec.eval[23])
               v[31:24] = 8'hff;
         end
         `REG_INITIAL_EVAL:
         begin
            v[23:0] = gen_status.initial_eval;
            if (gen_status.initial_eval[23])
               v[31:24] = 8'hff;
         end
         `REG_RESULT_UCI:
         begin
            for (k = 0; k < 4; k++)
               v[4*k +: 3] = move_rec.uci[3*k +: 3]; // Top bit of each nibble zero
            v[19:16] = move_rec.uci[15:12];
         end
         default:
         begin
            if (idx >= `REG_NEW_BOARD && idx < `REG_NEW_BOARD + `BOARD_WORDS)
               v = model_cfg.new_board[idx - `REG_NEW_BOARD];
            else if (idx >= `REG_RESULT_BOARD && idx < `REG_RESULT_BOARD + `BOARD_WORDS)
               v = move_rec.board[idx - `REG_RESULT_BOARD];
         end
      endcase
      return v;
   endfunction

   `include "tb_axil_tasks.svh"

   task automatic write_check(input logic [`REG_ADDR_WIDTH-1:0] idx, input logic [31:0] d,
                              input int order);
      int          strobes_before;
      logic [31:0] r;
      strobes_before = strobe_count;
      get_rand(2, r);
      axil_write({idx, 2'b00}, d, order, r[1:0]);
      if (strobe_count != strobes_before + 1)
         protocol_error($sformatf("%0d register updates for one write",
                                  strobe_count - strobes_before));
      model_write(idx, d);
      check_value("cfg", cfg, model_cfg);
   endtask

   task automatic read_check(input logic [`REG_ADDR_WIDTH-1:0] idx);
      logic [31:0] got;
      axil_read({idx, 2'b00}, got);
      check_value($sformatf("rdata[%0d]", idx), got, expected_read(idx));
   endtask

   initial
   begin
      int                         i;
      int                         k;
      int                         order;
      logic [31:0]                r;
      logic [31:0]                d;
      logic [`REG_ADDR_WIDTH-1:0] idx;
      logic [383:0]               wide;
      lfsr_state = 16'd81;
      rst_n      = 1'b0;
      awaddr     = '0;
      awvalid    = 1'b0;
      wdata      = '0;
      wvalid     = 1'b0;
      bready     = 1'b0;
      araddr     = '0;
      arvalid    = 1'b0;
      rready     = 1'b0;
      gen_status = '0;
      move_rec   = '0;
      model_cfg  = '0;
      wide       = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;

      check_value("cfg", cfg, '0);
      if (bvalid || rvalid)
         protocol_error("bvalid or rvalid high after reset");
      if (!awready || !wready || !arready)
         protocol_error("a ready signal is low after reset");
      for (i = 0; i < CFG_ADDRS; i++)
         read_check(cfg_addr(i));

      for (i = 0; i < RANDOM_WRITES; i++)
      begin
         if (i < CFG_ADDRS)
            idx = cfg_addr(i); // Every word once before random picks
         else
         begin
            get_rand(4, r);
            idx = cfg_addr(r % CFG_ADDRS);
         end
         get_rand(32, d);
         get_rand(2, r);
         write_check(idx, d, r % 3);
         read_check(idx);
      end

      for (i = 0; i < UNMAPPED_ADDRS; i++)
      begin
         idx = (i < 3) ? 5 + i : 1000 * i + 200;
         get_rand(32, d);
         get_rand(2, r);
         write_check(idx, d, r % 3);
         read_check(idx);
      end

      for (k = 0; k < STATUS_ROUNDS; k++)
      begin
         for (i = 0; i < 12; i++)
         begin
            get_rand(32, r);
            wide = {wide[351:0], r};
         end
         gen_status = wide[$bits(gen_status_t)-1:0];
         move_rec   = wide[383 -: $bits(move_record_t)];
         read_check(`REG_CONTROL);
         for (i = `REG_RESULT_FLAGS; i <= `REG_RESULT_UCI; i++)
            read_check(i); // Word 137 reads zero
         for (i = 0; i < `BOARD_WORDS; i++)
            read_check(`REG_RESULT_BOARD + i);
      end

      for (k = 0; k < ORDER_ROUNDS; k++)
         for (order = 0; order < 3; order++)
         begin
            get_rand(4, r);
            idx = cfg_addr(r % CFG_ADDRS);
            get_rand(32, d);
            write_check(idx, d, order);
            read_check(idx);
         end

      $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
      if (value_errors == 0 && protocol_errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

//--- tb.f
+incdir+.
vchess_pkg.sv
axil_hold_reg.sv
axil_write_channel.sv
axil_read_channel.sv
ctrl_regs.sv
status_read_mux.sv
vchess_ctrl.sv
tb_vchess_ctrl.sv

//--- Bender.yml
package:
  name: vchess_ctrl

sources:
  - include_dirs:
      - .
    files:
      - vchess_pkg.sv
      - axil_hold_reg.sv
      - axil_write_channel.sv
      - axil_read_channel.sv
      - ctrl_regs.sv
      - status_read_mux.sv
      - vchess_ctrl.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_vchess_ctrl.sv
